/* addr_gen_defines.svh */
/* Widths, shifts and register slot numbers for the address generation stage.
   Included by the package and by every RTL file that sizes a signal. */

`ifndef ADDR_GEN_DEFINES_SVH
`define ADDR_GEN_DEFINES_SVH

`define ADDR_W    32
`define IMM_W     48
`define SEG_W     16
`define SEG_SHIFT 4
`define NUM_GPR   8
`define NUM_SEG   6

// fixed slots used by the string addresses
`define GPR_ESI   6
`define GPR_EDI   7
`define SEG_ES    0
`define SEG_DS    3

`endif

/* addr_gen_pkg.sv */
/* Types shared by the address generation RTL and its testbench.
   Register files are packed arrays indexed by the x86 register number. */

`include "addr_gen_defines.svh"

package addr_gen_pkg;

    // kind 3 was the mm register file, no longer decoded
    typedef enum logic [2:0] {
        kind_none  = 3'd0,
        kind_reg   = 3'd1,
        kind_seg   = 3'd2,
        kind_modrm = 3'd4,
        kind_imm   = 3'd5,
        kind_mem   = 3'd6,
        kind_sys   = 3'd7
    } operand_kind_e;

    typedef enum logic [2:0] {
        size_byte  = 3'd1,
        size_word  = 3'd2,
        size_dword = 3'd3
    } op_size_e;

    // index 0 is eax, then ecx, edx, ebx, esp, ebp, esi, edi
    typedef logic [`NUM_GPR-1:0][31:0] gpr_file_t;

    // index 0 is es, then cs, ss, ds, fs, gs
    typedef logic [`NUM_SEG-1:0][`SEG_W-1:0] seg_file_t;

    typedef struct packed {
        op_size_e             size;
        operand_kind_e        op0_kind;
        operand_kind_e        op1_kind;
        logic [2:0]           op0_reg;
        logic [2:0]           op1_reg;
        logic [`IMM_W-1:0]    imm;
        logic [1:0]           stack_op;
        logic [`ADDR_W-1:0]   stack_address;
        logic [2:0]           seg_override;
        logic                 seg_override_valid;
        logic [31:0]          pc;
        logic [15:0]          opcode;
    } agen_req_t;

    typedef struct packed {
        logic [31:0]          op0;
        logic [31:0]          op1;
        logic [2:0]           op0_reg;
        logic [2:0]           op1_reg;
        logic                 op0_is_address;
        logic                 op0_is_reg;
        logic                 op0_is_segment;
        logic                 op1_is_address;
        logic                 op1_is_reg;
        logic [1:0]           stack_op;
        logic [`ADDR_W-1:0]   stack_address;
        logic [31:0]          pc;
        logic [15:0]          opcode;
        logic                 to_sys_controller;
    } agen_result_t;

    typedef struct packed {
        logic is_address;
        logic is_reg;
        logic is_segment;
    } operand_flags_t;

    // segment lookup, slots 6 and 7 read as zero
    function automatic logic [`SEG_W-1:0] seg_at(seg_file_t segs, logic [2:0] idx);
        logic [`SEG_W-1:0] seg;
        seg = '0;
        if (idx < `NUM_SEG) begin
            seg = segs[idx];
        end
        return seg;
    endfunction

endpackage

/* reg_size_select.sv */
/* Narrows the general register file to the operand size of the request.
   Combinational, one copy feeds both operand selectors. */

`timescale 1ns/1ps

`include "addr_gen_defines.svh"

module reg_size_select (
    input  addr_gen_pkg::op_size_e  size,
    input  addr_gen_pkg::gpr_file_t gprs,
    output addr_gen_pkg::gpr_file_t sized
);

    import addr_gen_pkg::*;

    always_comb begin
        logic [31:0] low_reg;
        sized = '0;
        for (int i = 0; i < `NUM_GPR; i++) begin
            // byte slots 4..7 are ah, ch, dh, bh taken from eax..ebx
            low_reg = gprs[i % 4];
            case (size)
                size_byte: begin
                    if (i < 4) begin
                        sized[i] = {24'd0, gprs[i][7:0]};
                    end else begin
                        sized[i] = {24'd0, low_reg[15:8]};
                    end
                end
                size_word: begin
                    sized[i] = {16'd0, gprs[i][15:0]};
                end
                size_dword: begin
                    sized[i] = gprs[i];
                end
                default: begin
                    sized[i] = '0;
                end
            endcase
        end
    end

endmodule

/* string_addr_gen.sv */
/* Linear addresses of the string operands.
   dst is ES:EDI, src is DS:ESI or the override segment with ESI. */

`timescale 1ns/1ps

`include "addr_gen_defines.svh"

module string_addr_gen (
    input  addr_gen_pkg::seg_file_t segs,
    input  addr_gen_pkg::gpr_file_t gprs,
    input  logic [2:0]              seg_override,
    input  logic                    seg_override_valid,
    output logic [`ADDR_W-1:0]      dst_addr,
    output logic [`ADDR_W-1:0]      src_addr
);

    import addr_gen_pkg::*;

    logic [`SEG_W-1:0] src_seg;
    logic [`ADDR_W-1:0] es_base;
    logic [`ADDR_W-1:0] src_base;

    // destination segment is never overridden
    assign src_seg = seg_override_valid ? seg_at(segs, seg_override) : segs[`SEG_DS];

    assign es_base  = {{(`ADDR_W - `SEG_W){1'b0}}, segs[`SEG_ES]} << `SEG_SHIFT;
    assign src_base = {{(`ADDR_W - `SEG_W){1'b0}}, src_seg} << `SEG_SHIFT;

    assign dst_addr = es_base + gprs[`GPR_EDI];
    assign src_addr = src_base + gprs[`GPR_ESI];

endmodule

/* operand_select.sv */
/* Operand value mux driven by the operand kind.
   Instantiated once for op0 and once for op1, also reports what the value is. */

`timescale 1ns/1ps

`include "addr_gen_defines.svh"

module operand_select (
    input  addr_gen_pkg::operand_kind_e  kind,
    input  logic [2:0]                   reg_idx,
    input  addr_gen_pkg::gpr_file_t      sized,
    input  addr_gen_pkg::seg_file_t      segs,
    input  logic [`IMM_W-1:0]            imm,
    input  logic [`ADDR_W-1:0]           mem_addr,
    output logic [31:0]                  value,
    output addr_gen_pkg::operand_flags_t flags
);

    import addr_gen_pkg::*;

    logic [`SEG_W-1:0] seg_value;

    assign seg_value = seg_at(segs, reg_idx);

    always_comb begin
        value = '0;
        flags = '0;
        case (kind)
            kind_reg: begin
                value        = sized[reg_idx];
                flags.is_reg = 1'b1;
            end
            kind_seg: begin
                value            = {{(32 - `SEG_W){1'b0}}, seg_value};
                flags.is_segment = 1'b1;
            end
            kind_imm: begin
                // upper immediate bits belong to far pointers, not the operand
                value = imm[31:0];
            end
            kind_mem: begin
                value            = mem_addr;
                flags.is_address = 1'b1;
            end
            default: begin
                // none, modrm and sys carry no operand value
                value = '0;
            end
        endcase
    end

endmodule

/* pipe_stage.sv */
/* Single entry valid/ready register between address generation and memory read.
   Flush drops the held result, the payload itself is left as it was. */

`timescale 1ns/1ps

module pipe_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  addr_gen_pkg::agen_result_t in_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output addr_gen_pkg::agen_result_t out_data
);

    logic load;

    // accept when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

/* addr_gen_top.sv */
/* Address generation stage. Builds op0 and op1 from the request and the register
   snapshots, applies the pop override and registers the result in one stage. */

`timescale 1ns/1ps

`include "addr_gen_defines.svh"

module addr_gen_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       r_valid,
    output logic                       r_ready,
    input  addr_gen_pkg::agen_req_t    r_req,
    input  addr_gen_pkg::gpr_file_t    gprs,
    input  addr_gen_pkg::seg_file_t    segs,
    output logic                       a_valid,
    input  logic                       a_ready,
    output addr_gen_pkg::agen_result_t a_result
);

    import addr_gen_pkg::*;

    gpr_file_t          sized;
    logic [`ADDR_W-1:0] dst_addr;
    logic [`ADDR_W-1:0] src_addr;
    logic [31:0]        op0_value;
    logic [31:0]        op1_value;
    operand_flags_t     op0_flags;
    operand_flags_t     op1_flags;
    logic               is_pop;
    agen_result_t       result;

    reg_size_select size_sel (
        .size  (r_req.size),
        .gprs  (gprs),
        .sized (sized)
    );

    string_addr_gen str_addr (
        .segs               (segs),
        .gprs               (gprs),
        .seg_override       (r_req.seg_override),
        .seg_override_valid (r_req.seg_override_valid),
        .dst_addr           (dst_addr),
        .src_addr           (src_addr)
    );

    operand_select op0_sel (
        .kind     (r_req.op0_kind),
        .reg_idx  (r_req.op0_reg),
        .sized    (sized),
        .segs     (segs),
        .imm      (r_req.imm),
        .mem_addr (dst_addr),
        .value    (op0_value),
        .flags    (op0_flags)
    );

    operand_select op1_sel (
        .kind     (r_req.op1_kind),
        .reg_idx  (r_req.op1_reg),
        .sized    (sized),
        .segs     (segs),
        .imm      (r_req.imm),
        .mem_addr (src_addr),
        .value    (op1_value),
        .flags    (op1_flags)
    );

    // pops read their source from the top of stack
    assign is_pop = r_req.stack_op[1];

    always_comb begin
        result                   = '0;
        result.op0               = op0_value;
        result.op1               = is_pop ? r_req.stack_address : op1_value;
        result.op0_reg           = r_req.op0_reg;
        result.op1_reg           = r_req.op1_reg;
        result.op0_is_address    = op0_flags.is_address;
        result.op0_is_reg        = op0_flags.is_reg;
        result.op0_is_segment    = op0_flags.is_segment;
        result.op1_is_address    = op1_flags.is_address | is_pop;
        result.op1_is_reg        = op1_flags.is_reg;
        result.stack_op          = r_req.stack_op;
        result.stack_address     = r_req.stack_address;
        result.pc                = r_req.pc;
        result.opcode            = r_req.opcode;
        result.to_sys_controller = (r_req.op0_kind == kind_sys);
    end

    pipe_stage stage0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (result),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out_data  (a_result)
    );

endmodule

/* addr_gen_props.sv */
/* Handshake properties of the pipeline register, bound into pipe_stage.
   Held data, flush and back-pressure are checked on every clock. */

`timescale 1ns/1ps

module addr_gen_props (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       flush,
    input logic                       in_valid,
    input logic                       in_ready,
    input logic                       out_valid,
    input logic                       out_ready,
    input addr_gen_pkg::agen_result_t out_data
);

    // a stalled result must sit still
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("a_result changed while the stage was stalled");

    flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid)
        else $error("a_valid still high in the cycle after a flush");

    // back-pressure only while an accepted item still waits for a_ready
    ready_when_free: assert property (@(posedge clk) disable iff (!rst_n)
        !in_ready |-> !out_ready &&
            ($past(in_valid && in_ready && !flush) || $past(!in_ready && !flush)))
        else $error("r_ready low while the stage could accept");

endmodule

bind pipe_stage addr_gen_props stage_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

/* addr_gen_tb.sv */
/* Testbench for the address generation stage. Drives the vectors of addr_gen_input.txt
   under random output stalls and checks every result that leaves the stage, in order. */

`timescale 1ns/1ps

module addr_gen_tb;

    import addr_gen_pkg::*;

    localparam int NUM_VECS   = 23;
    localparam int FIELDS     = 28;
    localparam int MAX_CYCLES = 4 * NUM_VECS + 200;

    logic         clk;
    logic         rst_n;
    logic         flush;
    logic         r_valid;
    logic         r_ready;
    agen_req_t    r_req;
    gpr_file_t    gprs;
    seg_file_t    segs;
    logic         a_valid;
    logic         a_ready;
    agen_result_t a_result;
    logic [47:0]  vec_mem [NUM_VECS * FIELDS];
    int           exp_q[$];
    int           errors;
    int           passed;
    int           dropped;
    logic [15:0]  lfsr;

    addr_gen_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] state);
        return {1'b0, state[15:1]} ^ (state[0] ? 16'hb400 : 16'h0000);
    endfunction

    function automatic logic [47:0] field(int vec, int idx);
        return vec_mem[vec * FIELDS + idx];
    endfunction

    task automatic finish_run(bit ok);
        if (ok) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic apply_vector(int vec);
        r_req                    = '0;
        r_req.size               = op_size_e'(3'(field(vec, 1)));
        r_req.op0_kind           = operand_kind_e'(3'(field(vec, 2)));
        r_req.op1_kind           = operand_kind_e'(3'(field(vec, 3)));
        r_req.op0_reg            = 3'(field(vec, 4));
        r_req.op1_reg            = 3'(field(vec, 5));
        r_req.imm                = field(vec, 6);
        r_req.stack_op           = 2'(field(vec, 7));
        r_req.stack_address      = 32'(field(vec, 8));
        r_req.seg_override       = 3'(field(vec, 9));
        r_req.seg_override_valid = (field(vec, 10) != 0);
        // pc tags the vector so that ordering shows up in the compare
        r_req.pc                 = 32'h1000 + 32'(vec);
        r_req.opcode             = ~16'(vec);
        for (int i = 0; i < 8; i++) begin
            gprs[i] = 32'(field(vec, 11 + i));
        end
        for (int i = 0; i < 6; i++) begin
            segs[i] = 16'(field(vec, 19 + i));
        end
        r_valid = 1'b1;
    endtask

    task automatic check_result(int vec);
        logic [157:0] got;
        logic [157:0] exp;
        got = {a_result.pc, a_result.opcode, a_result.op0, a_result.op1,
               a_result.op0_reg, a_result.op1_reg, a_result.stack_op,
               a_result.stack_address, a_result.to_sys_controller,
               a_result.op0_is_address, a_result.op0_is_reg, a_result.op0_is_segment,
               a_result.op1_is_address, a_result.op1_is_reg};
        exp = {32'h1000 + 32'(vec), ~16'(vec), 32'(field(vec, 25)), 32'(field(vec, 26)),
               3'(field(vec, 4)), 3'(field(vec, 5)), 2'(field(vec, 7)),
               32'(field(vec, 8)), 6'(field(vec, 27))};
        assert (got == exp) else begin
            $display("[ERROR] %0t: test %0d result %h, expected %h",
                     $time, vec, got, exp);
            errors++;
        end
        if (got == exp) begin
            passed++;
        end
        $display("test %0d %s", vec, (got == exp) ? "passed" : "failed");
    endtask

    initial begin
        int vec;
        bit flush_next;
        bit exp_valid;
        vec         = 0;
        flush_next  = 1'b0;
        exp_valid   = 1'b0;
        errors      = 0;
        passed      = 0;
        dropped     = 0;
        lfsr        = 16'd16;
        rst_n       = 1'b0;
        flush       = 1'b0;
        r_valid     = 1'b0;
        r_req       = '0;
        gprs        = '0;
        segs        = '0;
        a_ready     = 1'b0;
        $readmemh("addr_gen_input.txt", vec_mem);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (!a_valid && r_ready) else begin
            $display("[ERROR] %0t: stage not empty and ready after reset", $time);
            errors++;
        end
        while (vec < NUM_VECS || exp_q.size() > 0) begin
            @(negedge clk);
            flush = flush_next;
            if (flush_next) begin
                // hold the victim so the flush is what removes it
                a_ready = 1'b0;
                r_valid = 1'b0;
            end else begin
                lfsr    = lfsr_next(lfsr);
                a_ready = lfsr[0];
                if (vec < NUM_VECS) begin
                    apply_vector(vec);
                end else begin
                    r_valid = 1'b0;
                end
            end
            @(posedge clk);
            // outputs still carry their pre-edge values here
            exp_valid = exp_q.size() > 0 || flush_next;
            assert (a_valid == exp_valid && r_ready == (!exp_valid || a_ready)) else begin
                $display("[ERROR] %0t: r_ready %b a_valid %b, expected %b %b",
                         $time, r_ready, a_valid, !exp_valid || a_ready, exp_valid);
                errors++;
            end
            if (a_valid && a_ready) begin
                if (exp_q.size() > 0) begin
                    check_result(exp_q.pop_front());
                end else begin
                    $display("unexpected result with pc %h at %0t", a_result.pc, $time);
                    errors++;
                end
            end
            if (flush) begin
                $display("test %0d dropped by flush", vec - 1);
                dropped++;
                flush_next = 1'b0;
            end else if (r_valid && r_ready) begin
                if (field(vec, 0) != 0) begin
                    flush_next = 1'b1;
                end else begin
                    exp_q.push_back(vec);
                end
                vec++;
            end
        end
        $display("tests %0d, passed %0d, dropped %0d, errors %0d",
                 NUM_VECS, passed, dropped, errors);
        finish_run(errors == 0 && passed + dropped == NUM_VECS);
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with results still missing", MAX_CYCLES);
        finish_run(1'b0);
    end

endmodule

/* addr_gen_input.txt */
// flush size k0 k1 r0 r1 imm stack_op stack_addr ovr ovr_valid eax..edi es..gs exp_op0 exp_op1 flags
// flags bits: sys, op0 addr, op0 reg, op0 seg, op1 addr, op1 reg; flush 1 drops the item
0 3 1 1 0 7 0 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 11223344 00000240 09
0 1 1 1 4 3 0 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00000033 00000001 09
0 1 1 1 7 2 0 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 000000ff 000000cc 09
0 2 1 1 5 6 0 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00009000 00000120 09
0 1 1 1 6 5 0 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 000000bb 00000077 09
0 0 1 1 0 1 0 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00000000 00000000 09
0 3 2 2 3 6 0 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00004000 00000000 04
0 3 2 5 5 0 abcd12345678 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00006000 12345678 04
0 3 0 4 1 2 abcd12345678 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00000000 00000000 00
0 3 4 0 1 2 0 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00000000 00000000 00
0 3 6 6 0 0 0 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00010240 00040120 12
0 3 1 6 0 0 0 0 0 4 1 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 11223344 00050120 0a
0 3 0 6 0 0 0 0 0 6 1 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00000000 00000120 02
0 3 6 6 0 0 0 0 0 4 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00010240 00040120 12
0 3 1 1 3 1 0 2 0000fffc 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 ddeeff01 0000fffc 0b
0 3 0 5 0 0 0000deadbeef 3 00007ff0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00000000 00007ff0 02
0 3 2 5 2 0 000000000042 1 00001234 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00003000 00000042 04
0 2 7 1 0 0 0 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 00000000 00003344 21
1 3 1 1 1 2 0 0 0 0 0 11223344 55667788 99aabbcc ddeeff01 00008000 00009000 00000120 00000240 1000 2000 3000 4000 5000 6000 55667788 99aabbcc 09
0 3 6 6 0 0 0 0 0 0 0 a5a5a5a5 00000000 00000000 00000000 00000000 00000000 00001000 00002000 0fff 0000 0000 0001 ffff 0000 00011ff0 00001010 12
0 1 1 6 4 0 0 0 0 4 1 a5a5a5a5 00000000 00000000 00000000 00000000 00000000 00001000 00002000 0fff 0000 0000 0001 ffff 0000 000000a5 00100ff0 0a
0 2 1 2 0 4 0 0 0 0 0 a5a5a5a5 00000000 00000000 00000000 00000000 00000000 00001000 00002000 0fff 0000 0000 0001 ffff 0000 0000a5a5 0000ffff 08
0 3 6 0 0 0 0 0 0 4 1 a5a5a5a5 00000000 00000000 00000000 00000000 00000000 00001000 00002000 0fff 0000 0000 0001 ffff 0000 00011ff0 00000000 10

/* addr_gen.f */
+incdir+.
addr_gen_pkg.sv
reg_size_select.sv
string_addr_gen.sv
operand_select.sv
pipe_stage.sv
addr_gen_top.sv
addr_gen_props.sv
addr_gen_tb.sv

/* Makefile */
sim:
	verilator --binary --assert -Wno-fatal --top-module addr_gen_tb -f addr_gen.f -o addr_gen_sim
	./obj_dir/addr_gen_sim | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
